// File: list.f
rtl/uop_pkg.sv
rtl/rs_cfg_pkg.sv
rtl/rs_ifs.sv
rtl/tag_match_cam.sv
rtl/priority_picker.sv
rtl/rs_station.sv
rtl/rs_top.sv
test/rs_props.sv
test/rs_top_tb.sv

// File: Makefile
# Verilator build and run for the reservation station testbench
VERILATOR ?= verilator
TOP       ?= rs_top_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/rs_top_tb.sv
// Reservation station testbench
// Directed table and seeded random traffic, every issue port and full
// compared against a behavioral model of the station
`timescale 1ns/1ps
`default_nettype none

module rs_top_tb;
	import uop_pkg::*;
	import rs_cfg_pkg::*;

	localparam int rand_cycles = 200;

	// One row is one cycle of stimulus, exp is the issue vector a cycle later
	typedef struct {
		logic              dv;
		uop_t              u;
		logic              cv;
		tag_t              ct;
		logic [1:0]        stl;
		logic [num_fu-1:0] exp;
	} row_t;

	logic                      clock = 1'b0;
	logic                      reset;
	logic                      disp_valid;
	fu_class_t                 disp_fu;
	op_t                       disp_op;
	tag_t                      disp_dest;
	tag_t                      disp_src1;
	tag_t                      disp_src2;
	logic                      disp_rdy1;
	logic                      disp_rdy2;
	logic                      cdb_valid;
	tag_t                      cdb_tag;
	logic                      ld_stall;
	logic                      st_stall;
	logic                      full;
	logic [num_fu-1:0]         issue_valid;
	op_t [num_fu-1:0]          issue_op;
	tag_t [num_fu-1:0]         issue_dest;
	tag_t [num_fu-1:0]         issue_src1;
	tag_t [num_fu-1:0]         issue_src2;

	row_t rows [$];
	row_t rr;
	logic table_built = 1'b0;
	int   checks = 0;
	int   errors = 0;
	int   seed;
	tag_t dest_ctr;
	logic clash;

	// Model state
	logic              m_busy [rs_size];
	uop_t              m_uop [rs_size];
	logic [num_fu-1:0] exp_valid;
	uop_t              exp_uop [num_fu];
	logic              exp_full;

	rs_top uut (.*);

	always #10 clock = ~clock;

	// ----------------------------------------------------------
	// Model and checks
	// ----------------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error: %s = %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	// One clock edge of the station as seen from its rules
	task automatic model_step(input row_t r);
		int   pick [num_fu];
		int   slot;
		int   used;
		uop_t nu;
		for (int c = 0; c < num_fu; c++) begin
			pick[c] = -1;
			for (int i = 0; i < rs_size; i++)
				if (pick[c] < 0 && m_busy[i] && m_uop[i].rdy1 && m_uop[i].rdy2 &&
						int'(m_uop[i].fu) == c)
					pick[c] = i;
		end
		// Stalled classes pick nothing this cycle
		if (r.stl[0])
			pick[int'(fu_load)] = -1;
		if (r.stl[1])
			pick[int'(fu_store)] = -1;
		for (int c = 0; c < num_fu; c++) begin
			exp_valid[c] = (pick[c] >= 0);
			if (pick[c] >= 0)
				exp_uop[c] = m_uop[pick[c]];
		end
		// Lowest slot free before the edge takes the dispatch
		slot = -1;
		for (int i = 0; i < rs_size; i++)
			if (slot < 0 && !m_busy[i])
				slot = i;
		for (int i = 0; i < rs_size; i++) begin
			if (r.cv && m_uop[i].src1 == r.ct)
				m_uop[i].rdy1 = 1'b1;
			if (r.cv && m_uop[i].src2 == r.ct)
				m_uop[i].rdy2 = 1'b1;
		end
		for (int c = 0; c < num_fu; c++)
			if (pick[c] >= 0)
				m_busy[pick[c]] = 1'b0;
		if (r.dv && slot >= 0) begin
			nu = r.u;
			// Same-cycle broadcast also wakes the incoming micro-op
			nu.rdy1 = nu.rdy1 | (r.cv && nu.src1 == r.ct);
			nu.rdy2 = nu.rdy2 | (r.cv && nu.src2 == r.ct);
			m_uop[slot] = nu;
			m_busy[slot] = 1'b1;
		end
		used = 0;
		for (int i = 0; i < rs_size; i++)
			used += int'(m_busy[i]);
		exp_full = (used == rs_size);
	endtask

	task automatic compare_model();
		check("full", full, exp_full);
		check("issue_valid", issue_valid, exp_valid);
		for (int c = 0; c < num_fu; c++) begin
			if (exp_valid[c]) begin
				check($sformatf("issue_op[%0d]", c), issue_op[c], exp_uop[c].op);
				check($sformatf("issue_dest[%0d]", c), issue_dest[c], exp_uop[c].dest);
				check($sformatf("issue_src1[%0d]", c), issue_src1[c], exp_uop[c].src1);
				check($sformatf("issue_src2[%0d]", c), issue_src2[c], exp_uop[c].src2);
			end
		end
	endtask

	// Drive on the falling edge, the model follows the same inputs
	task automatic apply(input row_t r);
		disp_valid = r.dv;
		disp_fu = r.u.fu;
		disp_op = r.u.op;
		disp_dest = r.u.dest;
		disp_src1 = r.u.src1;
		disp_src2 = r.u.src2;
		disp_rdy1 = r.u.rdy1;
		disp_rdy2 = r.u.rdy2;
		cdb_valid = r.cv;
		cdb_tag = r.ct;
		ld_stall = r.stl[0];
		st_stall = r.stl[1];
		model_step(r);
	endtask

	// ----------------------------------------------------------
	// Stimulus table
	// ----------------------------------------------------------
	task automatic add_row(input logic dv, input fu_class_t fu, input tag_t dest,
			input tag_t s1, input logic r1, input tag_t s2, input logic r2, input logic cv,
			input tag_t ct, input logic [1:0] stl, input logic [num_fu-1:0] exp);
		row_t r;
		r.dv = dv;
		r.u = '{fu: fu, op: {2'b11, dest}, dest: dest, src1: s1, src2: s2, rdy1: r1, rdy2: r2};
		r.cv = cv;
		r.ct = ct;
		r.stl = stl;
		r.exp = exp;
		rows.push_back(r);
	endtask

	task automatic idle_row(input logic cv, input tag_t ct, input logic [1:0] stl,
			input logic [num_fu-1:0] exp);
		add_row(1'b0, fu_alu, 6'h00, 6'h00, 1'b0, 6'h00, 1'b0, cv, ct, stl, exp);
	endtask

	task automatic build_table();
		// Ready dispatch, then wakeups incl. broadcast with dispatch
		add_row(1, fu_alu, 6'h01, 6'h00, 1, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b00001);
		add_row(1, fu_mult, 6'h02, 6'h10, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		idle_row(1, 6'h10, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b00010);
		add_row(1, fu_branch, 6'h03, 6'h11, 0, 6'h00, 1, 1, 6'h11, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b10000);
		add_row(1, fu_alu, 6'h04, 6'h12, 0, 6'h13, 0, 0, 6'h00, 2'b00, 5'b00000);
		idle_row(1, 6'h12, 2'b00, 5'b00000);
		idle_row(1, 6'h13, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b00001);
		// Seven waiters on one tag, all classes go together
		add_row(1, fu_alu, 6'h05, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_alu, 6'h06, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_alu, 6'h07, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_mult, 6'h0a, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_load, 6'h08, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_store, 6'h09, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_branch, 6'h0b, 6'h30, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		idle_row(1, 6'h30, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b11111);
		idle_row(0, 6'h00, 2'b00, 5'b00001);
		idle_row(0, 6'h00, 2'b00, 5'b00001);
		// LSQ stalls, stl is {st, ld}
		add_row(1, fu_load, 6'h0c, 6'h00, 1, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		add_row(1, fu_store, 6'h0d, 6'h00, 1, 6'h00, 1, 0, 6'h00, 2'b01, 5'b00000);
		add_row(1, fu_alu, 6'h0e, 6'h00, 1, 6'h00, 1, 0, 6'h00, 2'b11, 5'b00000);
		idle_row(0, 6'h00, 2'b10, 5'b00101);
		idle_row(0, 6'h00, 2'b00, 5'b01000);
		// Fill all twelve slots, then drain and refill slot 0
		for (int i = 0; i < rs_size; i++)
			add_row(1, fu_alu, tag_t'(16 + i), 6'h31, 0, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00000);
		idle_row(1, 6'h31, 2'b00, 5'b00000);
		idle_row(0, 6'h00, 2'b00, 5'b00001);
		add_row(1, fu_mult, 6'h1c, 6'h00, 1, 6'h00, 1, 0, 6'h00, 2'b00, 5'b00001);
		idle_row(0, 6'h00, 2'b00, 5'b00011);
		for (int i = 0; i < 9; i++)
			idle_row(0, 6'h00, 2'b00, 5'b00001);
	endtask

	// ----------------------------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------------------------
	initial begin
		reset = 1'b1;
		rr = '{dv: 1'b0, u: '0, cv: 1'b0, ct: '0, stl: 2'b00, exp: '0};
		apply(rr);
		for (int i = 0; i < rs_size; i++)
			m_busy[i] = 1'b0;
		exp_valid = '0;
		exp_full = 1'b0;
		seed = 32'h35b6;
		dest_ctr = 6'h1f;
		build_table();
		table_built = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check("issue_valid", issue_valid, '0);
		check("full", full, 1'b0);
		for (int k = 0; k < rows.size(); k++) begin
			apply(rows[k]);
			@(negedge clock);
			compare_model();
			check("issue_valid (table)", issue_valid, rows[k].exp);
		end
		// Random mix, dest tags stay unique among live entries
		for (int k = 0; k < rand_cycles; k++) begin
			do begin
				dest_ctr = dest_ctr + 1'b1;
				clash = 1'b0;
				for (int i = 0; i < rs_size; i++)
					if (m_busy[i] && m_uop[i].dest == dest_ctr)
						clash = 1'b1;
			end while (clash);
			rr.dv = !exp_full && (($random(seed) & 3) != 0);
			rr.u.fu = fu_class_t'(3'($unsigned($random(seed)) % num_fu));
			rr.u.op = 8'($random(seed));
			rr.u.dest = dest_ctr;
			rr.u.src1 = tag_t'($random(seed) & 7);
			rr.u.src2 = tag_t'($random(seed) & 7);
			rr.u.rdy1 = 1'($random(seed));
			rr.u.rdy2 = 1'($random(seed));
			rr.cv = (($random(seed) & 3) != 0);
			rr.ct = tag_t'($random(seed) & 7);
			rr.stl = (($random(seed) & 7) == 0) ? 2'($random(seed)) : 2'b00;
			apply(rr);
			@(negedge clock);
			compare_model();
		end
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			uut.u_station.u_props.fails);
		if (errors == 0 && uut.u_station.u_props.fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		wait (table_built == 1'b1);
		#((rows.size() + rand_cycles + 20) * 20);
		$display("Watchdog expired before the tests completed");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/rs_props.sv
// Station protocol checks
// Concurrent assertions bound into the reservation station
`timescale 1ns/1ps
`default_nettype none

module rs_props (
	input logic                                clock,
	input logic                                reset,
	input logic                                disp_valid,
	input uop_pkg::tag_t                       disp_dest,
	input logic                                full,
	input rs_cfg_pkg::rs_entry_t               entries [rs_cfg_pkg::rs_size],
	input logic [uop_pkg::num_fu-1:0]          issue_valid,
	input uop_pkg::tag_t [uop_pkg::num_fu-1:0] issue_dest
);
	import uop_pkg::*;
	import rs_cfg_pkg::*;

	// Destination tags that issued and have not been dispatched since
	logic [2**tag_w-1:0] retired;
	// Live entries, counted from the busy flags
	int occupancy;
	// Failed assertions so far
	int fails = 0;

	always_comb begin
		occupancy = 0;
		for (int i = 0; i < rs_size; i++)
			occupancy = occupancy + int'(entries[i].busy);
	end

	// A dispatch in the same cycle as an issue of its tag wins
	always_ff @(posedge clock) begin
		if (reset) begin
			retired <= '0;
		end else begin
			for (int c = 0; c < num_fu; c++)
				if (issue_valid[c])
					retired[issue_dest[c]] <= 1'b1;
			if (disp_valid && !full)
				retired[disp_dest] <= 1'b0;
		end
	end

	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		disp_valid |-> !full)
		else begin
			fails++;
			$error("dispatch strobe while the station is full");
		end

	quiet_after_reset: assert property (@(posedge clock)
		reset |=> issue_valid == '0)
		else begin
			fails++;
			$error("issue strobe right after reset");
		end

	full_matches_count: assert property (@(posedge clock) disable iff (reset)
		full == (occupancy == rs_size))
		else begin
			fails++;
			$error("full disagrees with occupancy");
		end

	// One issue per dispatched destination tag
	for (genvar c = 0; c < num_fu; c++) begin : g_issue
		issue_once: assert property (@(posedge clock) disable iff (reset)
			issue_valid[c] |-> !retired[issue_dest[c]])
			else begin
				fails++;
				$error("destination tag issued twice on class %0d", c);
			end
	end

endmodule

bind rs_station rs_props u_props (
	.clock       (clock),
	.reset       (reset),
	.disp_valid  (disp.valid),
	.disp_dest   (in_uop.dest),
	.full        (full_q),
	.entries     (slots),
	.issue_valid (iss.valid),
	.issue_dest  (iss.dest)
);

`default_nettype wire

// File: rtl/rs_top.sv
// Reservation station top level
// Plain dispatch, CDB and stall ports in, flattened per-class issue
// ports out, all routed through the station interfaces
`timescale 1ns/1ps
`default_nettype none

module rs_top (
	input  logic                                 clock,
	input  logic                                 reset,
	// Dispatch
	input  logic                                 disp_valid,
	input  uop_pkg::fu_class_t                   disp_fu,
	input  uop_pkg::op_t                         disp_op,
	input  uop_pkg::tag_t                        disp_dest,
	input  uop_pkg::tag_t                        disp_src1,
	input  uop_pkg::tag_t                        disp_src2,
	input  logic                                 disp_rdy1,
	input  logic                                 disp_rdy2,
	// Common data bus and LSQ stalls
	input  logic                                 cdb_valid,
	input  uop_pkg::tag_t                        cdb_tag,
	input  logic                                 ld_stall,
	input  logic                                 st_stall,
	// Status and issue, indexed by class
	output logic                                 full,
	output logic [uop_pkg::num_fu-1:0]           issue_valid,
	output uop_pkg::op_t [uop_pkg::num_fu-1:0]   issue_op,
	output uop_pkg::tag_t [uop_pkg::num_fu-1:0]  issue_dest,
	output uop_pkg::tag_t [uop_pkg::num_fu-1:0]  issue_src1,
	output uop_pkg::tag_t [uop_pkg::num_fu-1:0]  issue_src2
);
	dispatch_if disp ();
	issue_if    iss ();

	// Pack the dispatch fields into one micro-op
	assign disp.valid = disp_valid;
	assign disp.uop = '{
		fu:   disp_fu,
		op:   disp_op,
		dest: disp_dest,
		src1: disp_src1,
		src2: disp_src2,
		rdy1: disp_rdy1,
		rdy2: disp_rdy2
	};
	assign full = disp.full;

	// Issue arrays straight out
	assign issue_valid = iss.valid;
	assign issue_op = iss.op;
	assign issue_dest = iss.dest;
	assign issue_src1 = iss.src1;
	assign issue_src2 = iss.src2;

	rs_station u_station (
		.clock     (clock),
		.reset     (reset),
		.disp      (disp),
		.iss       (iss),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.ld_stall  (ld_stall),
		.st_stall  (st_stall)
	);

endmodule

`default_nettype wire

// File: rtl/rs_station.sv
// Reservation station
// Holds renamed micro-ops until both sources are ready, wakes them
// from the CDB and issues up to one micro-op per function-unit class
`timescale 1ns/1ps
`default_nettype none

module rs_station (
	input  logic          clock,
	input  logic          reset,
	dispatch_if.sink      disp,
	issue_if.station      iss,
	input  logic          cdb_valid,
	input  uop_pkg::tag_t cdb_tag,
	input  logic          ld_stall,
	input  logic          st_stall
);
	import uop_pkg::*;
	import rs_cfg_pkg::*;

	// Entry table and occupancy
	rs_entry_t slots      [rs_size];
	rs_entry_t slots_next [rs_size];
	count_t    count;
	count_t    count_next;
	count_t    issued;
	logic      full_q;

	// Wakeup
	logic [rs_size-1:0] hit1;
	logic [rs_size-1:0] hit2;
	uop_t               in_uop;

	// Allocation
	logic [rs_size-1:0] free_req;
	logic [rs_size-1:0] free_gnt;
	logic               free_any;
	logic               accept;

	// Selection
	logic [rs_size-1:0] cls_req [num_fu];
	logic [rs_size-1:0] cls_gnt [num_fu];
	logic [num_fu-1:0]  cls_any;
	logic [num_fu-1:0]  blocked;
	logic [rs_size-1:0] issue_gnt;
	uop_t               sel_uop [num_fu];

	// ----------------------------------------------------------
	// Wakeup
	// ----------------------------------------------------------
	tag_match_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.entries   (slots),
		.hit1      (hit1),
		.hit2      (hit2)
	);

	// Incoming micro-op sees the same broadcast
	always_comb begin
		in_uop = disp.uop;
		in_uop.rdy1 = disp.uop.rdy1 | (cdb_valid && disp.uop.src1 == cdb_tag);
		in_uop.rdy2 = disp.uop.rdy2 | (cdb_valid && disp.uop.src2 == cdb_tag);
	end

	// ----------------------------------------------------------
	// Selection
	// ----------------------------------------------------------
	// LSQ stalls only mask their own class, for this cycle only
	always_comb begin
		blocked = '0;
		blocked[fu_load] = ld_stall;
		blocked[fu_store] = st_stall;
	end

	// Ready vector per class from registered ready bits
	always_comb begin
		for (int c = 0; c < num_fu; c++) begin
			for (int i = 0; i < rs_size; i++) begin
				cls_req[c][i] = slots[i].busy && slots[i].uop.rdy1 &&
					slots[i].uop.rdy2 && !blocked[c] &&
					(slots[i].uop.fu == fu_class_t'(c));
			end
		end
	end

	for (genvar c = 0; c < num_fu; c++) begin : g_class
		priority_picker #(.width(rs_size)) u_pick (
			.req (cls_req[c]),
			.gnt (cls_gnt[c]),
			.any (cls_any[c])
		);
	end

	// Mux the granted entry per class, count the issued ones
	always_comb begin
		issue_gnt = '0;
		issued = '0;
		for (int c = 0; c < num_fu; c++) begin
			sel_uop[c] = slots[0].uop;
			for (int i = 0; i < rs_size; i++) begin
				if (cls_gnt[c][i])
					sel_uop[c] = slots[i].uop;
			end
			issue_gnt = issue_gnt | cls_gnt[c];
			issued = issued + count_t'(cls_any[c]);
		end
	end

	// ----------------------------------------------------------
	// Allocation and next state
	// ----------------------------------------------------------
	// Slots freed this cycle are only writable next cycle
	always_comb begin
		for (int i = 0; i < rs_size; i++)
			free_req[i] = ~slots[i].busy;
	end

	priority_picker #(.width(rs_size)) u_free_pick (
		.req (free_req),
		.gnt (free_gnt),
		.any (free_any)
	);

	// A strobe while full finds no free slot and is dropped
	assign accept = disp.valid & free_any;

	always_comb begin
		slots_next = slots;
		for (int i = 0; i < rs_size; i++) begin
			slots_next[i].uop.rdy1 = slots[i].uop.rdy1 | hit1[i];
			slots_next[i].uop.rdy2 = slots[i].uop.rdy2 | hit2[i];
			if (issue_gnt[i])
				slots_next[i].busy = 1'b0;
			if (accept && free_gnt[i]) begin
				slots_next[i].busy = 1'b1;
				slots_next[i].uop = in_uop;
			end
		end
		count_next = count + count_t'(accept) - issued;
	end

	// Control state, entry payload keeps its value through reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rs_size; i++)
				slots[i].busy <= 1'b0;
			count <= '0;
			full_q <= 1'b0;
			iss.valid <= '0;
		end else begin
			slots <= slots_next;
			count <= count_next;
			full_q <= (count_next == count_t'(rs_size));
			iss.valid <= cls_any;
		end
	end

	// Issue payload, qualified by iss.valid
	always_ff @(posedge clock) begin
		for (int c = 0; c < num_fu; c++) begin
			iss.op[c] <= sel_uop[c].op;
			iss.dest[c] <= sel_uop[c].dest;
			iss.src1[c] <= sel_uop[c].src1;
			iss.src2[c] <= sel_uop[c].src2;
		end
	end

	assign disp.full = full_q;

endmodule

`default_nettype wire

// File: rtl/priority_picker.sv
// Lowest-index picker
// Two-level one-hot grant over a request vector: four-wide groups
// resolve locally, the lowest requesting group gets the grant
`timescale 1ns/1ps
`default_nettype none

module priority_picker #(
	parameter int width = 12
) (
	input  logic [width-1:0] req,
	output logic [width-1:0] gnt,
	output logic             any
);
	// Request vector rounded up to whole groups
	localparam int groups = (width + 3) / 4;
	localparam int padded = groups * 4;

	logic [padded-1:0] req_pad;
	logic [padded-1:0] gnt_pad;
	logic [groups-1:0] grp_req;
	logic [groups-1:0] grp_gnt;

	// Lowest set bit of a four-wide slice
	function automatic logic [3:0] first_of_four(input logic [3:0] r);
		logic [3:0] g;
		g[0] = r[0];
		g[1] = r[1] & ~r[0];
		g[2] = r[2] & ~|r[1:0];
		g[3] = r[3] & ~|r[2:0];
		return g;
	endfunction

	assign req_pad = padded'(req);

	// Upper level, isolate the lowest requesting group
	assign grp_gnt = grp_req & (~grp_req + 1'b1);

	// Lower level, each group enabled by its group grant
	for (genvar g = 0; g < groups; g++) begin : g_group
		assign grp_req[g] = |req_pad[4*g +: 4];
		assign gnt_pad[4*g +: 4] = first_of_four(req_pad[4*g +: 4]) & {4{grp_gnt[g]}};
	end

	assign gnt = gnt_pad[width-1:0];
	assign any = |grp_req;

endmodule

`default_nettype wire

// File: rtl/tag_match_cam.sv
// Wakeup CAM
// Compares the common data bus tag against both source tags of
// every live entry in the station
`timescale 1ns/1ps
`default_nettype none

module tag_match_cam (
	input  logic                           cdb_valid,
	input  uop_pkg::tag_t                  cdb_tag,
	input  rs_cfg_pkg::rs_entry_t          entries [rs_cfg_pkg::rs_size],
	output logic [rs_cfg_pkg::rs_size-1:0] hit1,
	output logic [rs_cfg_pkg::rs_size-1:0] hit2
);
	import rs_cfg_pkg::*;

	// One comparator pair per slot
	// Free slots never hit, their tags may be left over from
	// an earlier micro-op
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			hit1[i] = cdb_valid && entries[i].busy &&
				(entries[i].uop.src1 == cdb_tag);
			hit2[i] = cdb_valid && entries[i].busy &&
				(entries[i].uop.src2 == cdb_tag);
		end
	end

endmodule

`default_nettype wire

// File: rtl/rs_ifs.sv
// Station interfaces
// dispatch_if carries one micro-op strobe into the station,
// issue_if carries one strobe per function-unit class out of it
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------
// Dispatch side
// ----------------------------------------------------------
interface dispatch_if;
	import uop_pkg::*;

	logic valid;
	uop_t uop;
	// Source must hold off its strobe while this is high
	logic full;

	modport source (output valid, output uop, input full);
	modport sink (input valid, input uop, output full);
endinterface

// ----------------------------------------------------------
// Issue side, arrays indexed by fu_class_t
// ----------------------------------------------------------
interface issue_if;
	import uop_pkg::*;

	logic [num_fu-1:0]   valid;
	op_t  [num_fu-1:0]   op;
	tag_t [num_fu-1:0]   dest;
	tag_t [num_fu-1:0]   src1;
	tag_t [num_fu-1:0]   src2;

	modport station (
		output valid, output op, output dest, output src1, output src2
	);
	modport unit (
		input valid, input op, input dest, input src1, input src2
	);
endinterface

`default_nettype wire

// File: rtl/rs_cfg_pkg.sv
// Reservation station configuration
// Entry count, slot index width and the stored entry record
`default_nettype none

package rs_cfg_pkg;

	// Station geometry
	localparam int rs_size = 12;
	localparam int slot_w  = 4;

	// One extra bit so a full station can be counted
	typedef logic [slot_w:0] count_t;

	// Stored entry
	// busy marks a live micro-op, a cleared slot keeps stale fields
	typedef struct packed {
		logic          busy;
		uop_pkg::uop_t uop;
	} rs_entry_t;

endpackage

`default_nettype wire

// File: rtl/uop_pkg.sv
// Micro-op package
// Physical tags, opcode payload, function-unit classes and the
// renamed micro-op record that travels from dispatch to issue
`default_nettype none

package uop_pkg;

	// Physical register tag
	localparam int tag_w = 6;
	typedef logic [tag_w-1:0] tag_t;

	// Opcode is carried through untouched
	typedef logic [7:0] op_t;

	// Function-unit classes, one issue port each
	typedef enum logic [2:0] {
		fu_alu    = 3'd0,
		fu_mult   = 3'd1,
		fu_load   = 3'd2,
		fu_store  = 3'd3,
		fu_branch = 3'd4
	} fu_class_t;

	localparam int num_fu = 5;

	// Renamed micro-op, sources carry their own ready bits
	typedef struct packed {
		fu_class_t fu;
		op_t       op;
		tag_t      dest;
		tag_t      src1;
		tag_t      src2;
		logic      rdy1;
		logic      rdy2;
	} uop_t;

endpackage

`default_nettype wire
